/* common/hub_defines.svh */
//////////////////////////////
// Widths, field positions and queue depths of the descriptor hub
//////////////////////////////

`ifndef HUB_DEFINES_SVH
`define HUB_DEFINES_SVH

// Descriptor word
`define HUB_DESC_WIDTH  64

// Type nibble selects the destination queue
`define HUB_TYPE_MSB    63
`define HUB_TYPE_LSB    60

// Output port field, rewritten for DRAM writes
`define HUB_PORT_LSB    24
`define HUB_PORT_WIDTH  2
`define HUB_DRAM_PORT   2'd2

// Queue depths
`define HUB_SEND_DEPTH  8
`define HUB_DRAM_DEPTH  16
`define HUB_RECV_DEPTH  8

// Top byte of a scheduler word that carries a core reset command
`define HUB_RESET_MARK  8'hFF

`endif

/* common/hub_pkg.sv */
//////////////////////////////
// Descriptor, DRAM descriptor and type nibble types
//////////////////////////////

`include "hub_defines.svh"

package hub_pkg;

  // One descriptor word as it travels between core, scheduler and DMA
  typedef logic [`HUB_DESC_WIDTH-1:0] desc_t;

  // DRAM write entry with the address in the upper half
  typedef struct packed {
    logic [63:0] addr;
    desc_t       desc;
  } dram_desc_t;

  // Encoding of the type nibble in bits 63:60
  typedef enum logic [3:0] {
    DATA_SEND  = 4'd0,
    CTRL_MSG_A = 4'd1,
    CTRL_MSG_B = 4'd2,
    CTRL_MSG_C = 4'd3,
    DRAM_WR    = 4'd4,
    // Read requests go to a path outside this hub
    DRAM_RD    = 4'd5
  } desc_kind_e;

endpackage

/* hw/desc_fifo.sv */
//////////////////////////////
// Synchronous FIFO, valid/ready on both sides, any payload type
//////////////////////////////

`timescale 1ns/1ps
`include "hub_defines.svh"

module desc_fifo
  import hub_pkg::*;
#(
  parameter type payload_t = desc_t,
  parameter int  DEPTH     = `HUB_SEND_DEPTH
) (
  input  logic     sys_clk,
  input  logic     sys_rst,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge sys_clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // A full queue must not take a word, an empty one must not give one
  a_no_write_full: assert property (@(posedge sys_clk) disable iff (sys_rst)
    (count == CNT_W'(DEPTH)) |=> $stable(wr_ptr));
  a_no_read_empty: assert property (@(posedge sys_clk) disable iff (sys_rst)
    (count == '0) |=> $stable(rd_ptr));

endmodule

/* hw/core_dispatch/core_desc_dispatch.sv */
//////////////////////////////
// Core send descriptor sorting into data, message and DRAM write queues
//////////////////////////////

`timescale 1ns/1ps
`include "hub_defines.svh"

module core_desc_dispatch
  import hub_pkg::*;
(
  input  logic        sys_clk,
  input  logic        sys_rst,
  input  logic        core_desc_valid,
  output logic        core_desc_ready,
  input  desc_t       core_desc,
  input  logic [63:0] core_dram_addr,
  output logic        data_head_valid,
  input  logic        data_head_ready,
  output desc_t       data_head,
  output logic        dram_head_valid,
  input  logic        dram_head_ready,
  output dram_desc_t  dram_head,
  output logic        ctrl_out_valid,
  input  logic        ctrl_out_ready,
  output desc_t       ctrl_out_data
);

  desc_kind_e kind;
  logic       to_data;
  logic       to_msg;
  logic       to_dram;
  logic       data_in_ready;
  logic       msg_in_ready;
  logic       dram_in_ready;
  dram_desc_t dram_entry;
  logic       msg_head_valid;
  logic       msg_head_ready;
  desc_t      msg_head;

  //////////////////////////////
  // Type decode
  //////////////////////////////
  assign kind = desc_kind_e'(core_desc[`HUB_TYPE_MSB:`HUB_TYPE_LSB]);

  always_comb begin
    to_data = 1'b0;
    to_msg  = 1'b0;
    to_dram = 1'b0;
    case (kind)
      DATA_SEND:                          to_data = 1'b1;
      CTRL_MSG_A, CTRL_MSG_B, CTRL_MSG_C: to_msg  = 1'b1;
      DRAM_WR:                            to_dram = 1'b1;
      // DRAM reads and unknown types are taken and dropped
      default: ;
    endcase
  end

  // Dropped types never stall the core
  assign core_desc_ready = to_data ? data_in_ready :
                           to_msg  ? msg_in_ready  :
                           to_dram ? dram_in_ready : 1'b1;

  // DRAM writes leave on the DRAM port with their address attached
  always_comb begin
    dram_entry.addr = core_dram_addr;
    dram_entry.desc = core_desc;
    dram_entry.desc[`HUB_PORT_LSB +: `HUB_PORT_WIDTH] = `HUB_DRAM_PORT;
  end

  //////////////////////////////
  // Per-type queues
  //////////////////////////////
  desc_fifo #(.payload_t(desc_t), .DEPTH(`HUB_SEND_DEPTH)) send_data_fifo (
    .sys_clk   (sys_clk),
    .sys_rst   (sys_rst),
    .in_valid  (core_desc_valid && to_data),
    .in_ready  (data_in_ready),
    .in_data   (core_desc),
    .out_valid (data_head_valid),
    .out_ready (data_head_ready),
    .out_data  (data_head)
  );

  desc_fifo #(.payload_t(desc_t), .DEPTH(`HUB_SEND_DEPTH)) send_msg_fifo (
    .sys_clk   (sys_clk),
    .sys_rst   (sys_rst),
    .in_valid  (core_desc_valid && to_msg),
    .in_ready  (msg_in_ready),
    .in_data   (core_desc),
    .out_valid (msg_head_valid),
    .out_ready (msg_head_ready),
    .out_data  (msg_head)
  );

  desc_fifo #(.payload_t(dram_desc_t), .DEPTH(`HUB_DRAM_DEPTH)) dram_wr_fifo (
    .sys_clk   (sys_clk),
    .sys_rst   (sys_rst),
    .in_valid  (core_desc_valid && to_dram),
    .in_ready  (dram_in_ready),
    .in_data   (dram_entry),
    .out_valid (dram_head_valid),
    .out_ready (dram_head_ready),
    .out_data  (dram_head)
  );

  //////////////////////////////
  // Scheduler message output register
  //////////////////////////////
  assign msg_head_ready = !ctrl_out_valid || ctrl_out_ready;

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      ctrl_out_valid <= 1'b0;
    end else if (msg_head_ready) begin
      ctrl_out_valid <= msg_head_valid;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (msg_head_valid && msg_head_ready) begin
      ctrl_out_data <= msg_head;
    end
  end

  a_one_push: assert property (@(posedge sys_clk) disable iff (sys_rst)
    $onehot0({core_desc_valid && to_data && data_in_ready,
              core_desc_valid && to_msg && msg_in_ready,
              core_desc_valid && to_dram && dram_in_ready}));

endmodule

/* hw/ctrl_intake.sv */
//////////////////////////////
// Scheduler word intake and core reset command
//////////////////////////////

`timescale 1ns/1ps
`include "hub_defines.svh"

module ctrl_intake
  import hub_pkg::*;
(
  input  logic  sys_clk,
  input  logic  sys_rst,
  input  logic  ctrl_in_valid,
  output logic  ctrl_in_ready,
  input  desc_t ctrl_in_data,
  output logic  sched_head_valid,
  input  logic  sched_head_ready,
  output desc_t sched_head,
  output logic  core_reset
);

  logic reset_cmd;

  assign reset_cmd = (ctrl_in_data[`HUB_DESC_WIDTH-1 -: 8] == `HUB_RESET_MARK);

  // Reset commands never enter the queue
  desc_fifo #(.payload_t(desc_t), .DEPTH(`HUB_RECV_DEPTH)) recvd_ctrl_fifo (
    .sys_clk   (sys_clk),
    .sys_rst   (sys_rst),
    .in_valid  (ctrl_in_valid && !reset_cmd),
    .in_ready  (ctrl_in_ready),
    .in_data   (ctrl_in_data),
    .out_valid (sched_head_valid),
    .out_ready (sched_head_ready),
    .out_data  (sched_head)
  );

  // Core held in reset until the scheduler releases it
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      core_reset <= 1'b1;
    end else if (ctrl_in_valid && ctrl_in_ready && reset_cmd) begin
      core_reset <= ctrl_in_data[0];
    end
  end

endmodule

/* hw/send_arbiter/send_arbiter.sv */
//////////////////////////////
// Priority and round-robin arbitration onto the send descriptor port
//////////////////////////////

`timescale 1ns/1ps

module send_arbiter
  import hub_pkg::*;
(
  input  logic        sys_clk,
  input  logic        sys_rst,
  input  logic        sched_head_valid,
  output logic        sched_head_ready,
  input  desc_t       sched_head,
  input  logic        data_head_valid,
  output logic        data_head_ready,
  input  desc_t       data_head,
  input  logic        dram_head_valid,
  output logic        dram_head_ready,
  input  dram_desc_t  dram_head,
  output logic        send_valid,
  input  logic        send_ready,
  output desc_t       send_desc,
  output logic [63:0] send_dram_addr
);

  typedef enum logic [1:0] {PICK_SCHED, PICK_DATA, PICK_DRAM} pick_e;

  logic  pkt_valid;
  logic  dram_turn;
  logic  stall_r;
  pick_e pick_free;
  pick_e pick_r;
  pick_e pick;

  assign pkt_valid  = sched_head_valid || data_head_valid;
  assign send_valid = pkt_valid || dram_head_valid;

  // Scheduler words beat core data, then DRAM alternates with packets
  always_comb begin
    if (dram_head_valid && (!pkt_valid || dram_turn)) begin
      pick_free = PICK_DRAM;
    end else if (sched_head_valid) begin
      pick_free = PICK_SCHED;
    end else begin
      pick_free = PICK_DATA;
    end
  end

  // Choice is frozen while the DMA side stalls so the offered word does not change
  assign pick = stall_r ? pick_r : pick_free;

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      stall_r <= 1'b0;
    end else begin
      stall_r <= send_valid && !send_ready;
    end
  end

  always_ff @(posedge sys_clk) begin
    pick_r <= pick;
  end

  always_comb begin
    case (pick)
      PICK_SCHED: send_desc = sched_head;
      PICK_DRAM:  send_desc = dram_head.desc;
      default:    send_desc = data_head;
    endcase
  end

  // Only meaningful when the type nibble says DRAM write
  assign send_dram_addr = dram_head.addr;

  assign sched_head_ready = send_ready && (pick == PICK_SCHED);
  assign data_head_ready  = send_ready && (pick == PICK_DATA);
  assign dram_head_ready  = send_ready && (pick == PICK_DRAM);

  //////////////////////////////
  // Round-robin turn
  //////////////////////////////
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      dram_turn <= 1'b0;
    end else if (dram_head_valid && dram_head_ready) begin
      dram_turn <= 1'b0;
    end else if (send_valid && send_ready) begin
      dram_turn <= 1'b1;
    end
  end

  a_one_pop: assert property (@(posedge sys_clk) disable iff (sys_rst)
    $onehot0({sched_head_valid && sched_head_ready,
              data_head_valid && data_head_ready,
              dram_head_valid && dram_head_ready}));

  a_send_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
    send_valid && !send_ready |=> send_valid && $stable(send_desc));

endmodule

/* hw/desc_hub_top.sv */
//////////////////////////////
// Descriptor hub top level
//////////////////////////////

`timescale 1ns/1ps

module desc_hub_top
  import hub_pkg::*;
(
  input  logic        sys_clk,
  input  logic        sys_rst,
  // Core side
  input  logic        core_desc_valid,
  output logic        core_desc_ready,
  input  desc_t       core_desc,
  input  logic [63:0] core_dram_addr,
  // From scheduler
  input  logic        ctrl_in_valid,
  output logic        ctrl_in_ready,
  input  desc_t       ctrl_in_data,
  // To DMA side
  output logic        send_valid,
  input  logic        send_ready,
  output desc_t       send_desc,
  output logic [63:0] send_dram_addr,
  // To scheduler
  output logic        ctrl_out_valid,
  input  logic        ctrl_out_ready,
  output desc_t       ctrl_out_data,
  output logic        core_reset
);

  logic       data_head_valid;
  logic       data_head_ready;
  desc_t      data_head;
  logic       dram_head_valid;
  logic       dram_head_ready;
  dram_desc_t dram_head;
  logic       sched_head_valid;
  logic       sched_head_ready;
  desc_t      sched_head;

  core_desc_dispatch dispatch (
    .sys_clk         (sys_clk),
    .sys_rst         (sys_rst),
    .core_desc_valid (core_desc_valid),
    .core_desc_ready (core_desc_ready),
    .core_desc       (core_desc),
    .core_dram_addr  (core_dram_addr),
    .data_head_valid (data_head_valid),
    .data_head_ready (data_head_ready),
    .data_head       (data_head),
    .dram_head_valid (dram_head_valid),
    .dram_head_ready (dram_head_ready),
    .dram_head       (dram_head),
    .ctrl_out_valid  (ctrl_out_valid),
    .ctrl_out_ready  (ctrl_out_ready),
    .ctrl_out_data   (ctrl_out_data)
  );

  ctrl_intake intake (
    .sys_clk          (sys_clk),
    .sys_rst          (sys_rst),
    .ctrl_in_valid    (ctrl_in_valid),
    .ctrl_in_ready    (ctrl_in_ready),
    .ctrl_in_data     (ctrl_in_data),
    .sched_head_valid (sched_head_valid),
    .sched_head_ready (sched_head_ready),
    .sched_head       (sched_head),
    .core_reset       (core_reset)
  );

  send_arbiter arbiter (
    .sys_clk          (sys_clk),
    .sys_rst          (sys_rst),
    .sched_head_valid (sched_head_valid),
    .sched_head_ready (sched_head_ready),
    .sched_head       (sched_head),
    .data_head_valid  (data_head_valid),
    .data_head_ready  (data_head_ready),
    .data_head        (data_head),
    .dram_head_valid  (dram_head_valid),
    .dram_head_ready  (dram_head_ready),
    .dram_head        (dram_head),
    .send_valid       (send_valid),
    .send_ready       (send_ready),
    .send_desc        (send_desc),
    .send_dram_addr   (send_dram_addr)
  );

endmodule

/* bench/desc_hub_ref.svh */
//////////////////////////////
// Routing rules of the hub and expected-value queues per source
//////////////////////////////

localparam int ROUTE_DATA = 0;
localparam int ROUTE_MSG  = 1;
localparam int ROUTE_DRAM = 2;
localparam int ROUTE_DROP = 3;

// One queue per source in arrival order
desc_t       exp_data_q  [$];
desc_t       exp_msg_q   [$];
desc_t       exp_dram_q  [$];
logic [63:0] exp_addr_q  [$];
desc_t       exp_sched_q [$];

// Destination chosen by the type nibble
function automatic int route_of(input desc_t d);
  case (d[`HUB_TYPE_MSB:`HUB_TYPE_LSB])
    4'd0:             return ROUTE_DATA;
    4'd1, 4'd2, 4'd3: return ROUTE_MSG;
    4'd4:             return ROUTE_DRAM;
    default:          return ROUTE_DROP;
  endcase
endfunction

// A DRAM write leaves with its port field pointing at DRAM
function automatic desc_t dram_form(input desc_t d);
  desc_t r;
  r = d;
  r[`HUB_PORT_LSB +: `HUB_PORT_WIDTH] = `HUB_DRAM_PORT;
  return r;
endfunction

function automatic logic is_reset_cmd(input desc_t w);
  return w[63:56] == `HUB_RESET_MARK;
endfunction

task automatic expect_core(input desc_t d, input logic [63:0] addr);
  case (route_of(d))
    ROUTE_DATA: exp_data_q.push_back(d);
    ROUTE_MSG:  exp_msg_q.push_back(d);
    ROUTE_DRAM: begin
      exp_dram_q.push_back(dram_form(d));
      exp_addr_q.push_back(addr);
    end
    default: ;
  endcase
endtask

task automatic expect_ctrl(input desc_t w);
  if (!is_reset_cmd(w)) begin
    exp_sched_q.push_back(w);
  end
endtask

function automatic int pending();
  return exp_data_q.size() + exp_msg_q.size() + exp_dram_q.size() + exp_sched_q.size();
endfunction

/* bench/desc_hub_tb.sv */
//////////////////////////////
// Testbench for the descriptor hub
//////////////////////////////

`timescale 1ns/1ps
`include "hub_defines.svh"

module desc_hub_tb
  import hub_pkg::*;
();

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int T6_CORE      = 60;
  localparam int T6_SCHED     = 20;
  localparam int TOTAL_WORDS  = 2 + 16 + 6 + 10 + 12 + T6_CORE + T6_SCHED;
  localparam int CYCLE_LIMIT  = 4 * TOTAL_WORDS + 200;

  logic        sys_clk;
  logic        sys_rst;
  logic        core_desc_valid;
  logic        core_desc_ready;
  desc_t       core_desc;
  logic [63:0] core_dram_addr;
  logic        ctrl_in_valid;
  logic        ctrl_in_ready;
  desc_t       ctrl_in_data;
  logic        send_valid;
  logic        send_ready;
  desc_t       send_desc;
  logic [63:0] send_dram_addr;
  logic        ctrl_out_valid;
  logic        ctrl_out_ready;
  desc_t       ctrl_out_data;
  logic        core_reset;

  integer      seed;
  int          errors;
  int          checks;
  int          cycles;
  int          idx;
  int          jdx;
  string       test_name;
  logic        bp_en;
  logic [31:0] bp_rand;
  logic [31:0] kind_r;
  logic        prio_check;
  logic        alt_check;
  logic        alt_prev_valid;
  logic        alt_prev_dram;
  desc_t       t6_core  [T6_CORE];
  logic [63:0] t6_addr  [T6_CORE];
  desc_t       t6_sched [T6_SCHED];

  `include "desc_hub_ref.svh"

  desc_hub_top UUT (
    .sys_clk         (sys_clk),
    .sys_rst         (sys_rst),
    .core_desc_valid (core_desc_valid),
    .core_desc_ready (core_desc_ready),
    .core_desc       (core_desc),
    .core_dram_addr  (core_dram_addr),
    .ctrl_in_valid   (ctrl_in_valid),
    .ctrl_in_ready   (ctrl_in_ready),
    .ctrl_in_data    (ctrl_in_data),
    .send_valid      (send_valid),
    .send_ready      (send_ready),
    .send_desc       (send_desc),
    .send_dram_addr  (send_dram_addr),
    .ctrl_out_valid  (ctrl_out_valid),
    .ctrl_out_ready  (ctrl_out_ready),
    .ctrl_out_data   (ctrl_out_data),
    .core_reset      (core_reset)
  );

  always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

  always @(posedge sys_clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the tests did not complete", cycles);
      $display("Checks run: %0d, errors: %0d", checks, errors + 1);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // Random back-pressure driven one step ahead of the stimulus
  always @(posedge sys_clk) begin
    #1;
    if (bp_en) begin
      bp_rand = $random(seed);
      send_ready = bp_rand[0] | bp_rand[1];
      ctrl_out_ready = bp_rand[2] | bp_rand[3];
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////
  task compare_word(input string label, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, label, exp, act);
      errors++;
    end
  endtask

  task check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("ERROR in %s: %s", test_name, what);
      errors++;
    end
  endtask

  task check_send();
    logic [3:0] kind;
    logic       is_dram;
    kind = send_desc[`HUB_TYPE_MSB:`HUB_TYPE_LSB];
    is_dram = (kind == 4'd4);
    if (alt_check) begin
      if (exp_dram_q.size() > 0 && (exp_data_q.size() + exp_sched_q.size()) > 0) begin
        if (alt_prev_valid) begin
          check_true(is_dram != alt_prev_dram, "DRAM and packet sends did not alternate");
        end
        alt_prev_valid = 1'b1;
        alt_prev_dram = is_dram;
      end else begin
        alt_prev_valid = 1'b0;
      end
    end
    if (prio_check && kind == 4'd0) begin
      check_true(exp_sched_q.size() == 0, "data descriptor sent before all scheduler words");
    end
    case (kind)
      4'd0: begin
        if (exp_data_q.size() == 0) begin
          check_true(1'b0, "unexpected data descriptor at send");
        end else begin
          compare_word("send data", exp_data_q.pop_front(), send_desc);
        end
      end
      4'd4: begin
        if (exp_dram_q.size() == 0) begin
          check_true(1'b0, "unexpected DRAM write at send");
        end else begin
          compare_word("send dram desc", exp_dram_q.pop_front(), send_desc);
          compare_word("send dram addr", exp_addr_q.pop_front(), send_dram_addr);
        end
      end
      4'd8: begin
        if (exp_sched_q.size() == 0) begin
          check_true(1'b0, "unexpected scheduler word at send");
        end else begin
          compare_word("send sched", exp_sched_q.pop_front(), send_desc);
        end
      end
      default: check_true(1'b0, $sformatf("descriptor of type %0d appeared at send", kind));
    endcase
  endtask

  task check_ctrl();
    if (exp_msg_q.size() == 0) begin
      check_true(1'b0, "unexpected message at ctrl_out");
    end else begin
      compare_word("ctrl_out msg", exp_msg_q.pop_front(), ctrl_out_data);
    end
  endtask

  // Transfers are sampled at the falling edge before the rising edge that completes them
  always @(negedge sys_clk) begin
    if (!sys_rst && send_valid && send_ready) begin
      check_send();
    end
    if (!sys_rst && ctrl_out_valid && ctrl_out_ready) begin
      check_ctrl();
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  function automatic desc_t rand_desc(input logic [3:0] kind);
    desc_t d;
    d = {$random(seed), $random(seed)};
    d[`HUB_TYPE_MSB:`HUB_TYPE_LSB] = kind;
    return d;
  endfunction

  function automatic logic [63:0] rand_addr();
    return {$random(seed), $random(seed)};
  endfunction

  task step();
    @(posedge sys_clk);
    #2;
  endtask

  // Starts just after a rising edge and returns just after the accepting edge
  task automatic drive_core(input desc_t d, input logic [63:0] addr);
    logic accepted;
    core_desc_valid = 1'b1;
    core_desc = d;
    core_dram_addr = addr;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge sys_clk);
      accepted = core_desc_ready;
    end
    expect_core(d, addr);
    step();
    core_desc_valid = 1'b0;
  endtask

  task automatic drive_ctrl(input desc_t w);
    logic accepted;
    ctrl_in_valid = 1'b1;
    ctrl_in_data = w;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge sys_clk);
      accepted = ctrl_in_ready;
    end
    expect_ctrl(w);
    step();
    ctrl_in_valid = 1'b0;
  endtask

  // Quiet cycles at the end catch duplicates
  task wait_drain();
    while (pending() != 0) begin
      @(negedge sys_clk);
    end
    repeat (4) @(posedge sys_clk);
    #2;
  endtask

  initial begin
    sys_clk = 1'b0;
    sys_rst = 1'b1;
    core_desc_valid = 1'b0;
    core_desc = '0;
    core_dram_addr = '0;
    ctrl_in_valid = 1'b0;
    ctrl_in_data = '0;
    send_ready = 1'b1;
    ctrl_out_ready = 1'b1;
    seed = 97166;
    errors = 0;
    checks = 0;
    cycles = 0;
    bp_en = 1'b0;
    prio_check = 1'b0;
    alt_check = 1'b0;
    alt_prev_valid = 1'b0;
    alt_prev_dram = 1'b0;
    test_name = "reset";
    repeat (RESET_CYCLES) @(posedge sys_clk);
    #2;
    sys_rst = 1'b0;

    // Reset commands from the scheduler
    test_name = "core_reset_cmd";
    compare_word("core_reset after reset", 64'd1, core_reset);
    compare_word("send_valid after reset", 64'd0, send_valid);
    compare_word("ctrl_out_valid after reset", 64'd0, ctrl_out_valid);
    drive_ctrl({`HUB_RESET_MARK, 56'h00_0000_0000_0000});
    compare_word("core_reset cleared", 64'd0, core_reset);
    drive_ctrl({`HUB_RESET_MARK, 55'h12_3456, 1'b1});
    compare_word("core_reset set", 64'd1, core_reset);
    wait_drain();

    // Every type nibble once
    test_name = "type_sorting";
    for (idx = 0; idx < 16; idx++) begin
      drive_core(rand_desc(idx[3:0]), rand_addr());
    end
    wait_drain();

    test_name = "dram_write";
    for (idx = 0; idx < 6; idx++) begin
      drive_core(rand_desc(4'd4), rand_addr());
    end
    wait_drain();

    test_name = "sched_priority";
    send_ready = 1'b0;
    prio_check = 1'b1;
    for (idx = 0; idx < 5; idx++) begin
      drive_ctrl(rand_desc(4'd8));
    end
    for (idx = 0; idx < 5; idx++) begin
      drive_core(rand_desc(4'd0), rand_addr());
    end
    repeat (3) step();
    send_ready = 1'b1;
    wait_drain();
    prio_check = 1'b0;

    test_name = "dram_round_robin";
    send_ready = 1'b0;
    alt_check = 1'b1;
    alt_prev_valid = 1'b0;
    for (idx = 0; idx < 6; idx++) begin
      drive_core(rand_desc(4'd0), rand_addr());
    end
    for (idx = 0; idx < 6; idx++) begin
      drive_core(rand_desc(4'd4), rand_addr());
    end
    repeat (3) step();
    send_ready = 1'b1;
    wait_drain();
    alt_check = 1'b0;

    // Mixed traffic with core types 0 to 7
    test_name = "random_backpressure";
    for (idx = 0; idx < T6_CORE; idx++) begin
      kind_r = $random(seed);
      t6_core[idx] = rand_desc({1'b0, kind_r[2:0]});
      t6_addr[idx] = rand_addr();
    end
    for (idx = 0; idx < T6_SCHED; idx++) begin
      t6_sched[idx] = rand_desc(4'd8);
    end
    bp_en = 1'b1;
    fork
      begin
        for (idx = 0; idx < T6_CORE; idx++) begin
          drive_core(t6_core[idx], t6_addr[idx]);
        end
      end
      begin
        for (jdx = 0; jdx < T6_SCHED; jdx++) begin
          drive_ctrl(t6_sched[jdx]);
        end
      end
    join
    wait_drain();
    bp_en = 1'b0;
    send_ready = 1'b1;
    ctrl_out_ready = 1'b1;
    wait_drain();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+common
+incdir+bench
common/hub_pkg.sv
hw/desc_fifo.sv
hw/core_dispatch/core_desc_dispatch.sv
hw/ctrl_intake.sv
hw/send_arbiter/send_arbiter.sv
hw/desc_hub_top.sv
bench/desc_hub_tb.sv
